// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

    // data path and instruction widths
    localparam int XLEN    = 64;
    localparam int INSTR_W = 32;

    // major opcode field, instruction bits [6:2]
    localparam logic [4:0] OPC_LOAD  = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;

    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LD,
        LBU,
        LHU,
        LWU,
        SB,
        SH,
        SW,
        SD,
        OP_ILLEGAL
    } mem_op_e;

    typedef enum logic [1:0] {
        ST_OK,
        ST_MISALIGNED,
        ST_ILLEGAL
    } rsp_status_e;

    // request as handed over by the core
    typedef struct packed {
        logic [INSTR_W-1:0] instr;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    wdata;
    } ls_req_t;

    // decoded command for the datapath
    typedef struct packed {
        mem_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } ls_cmd_t;

    typedef struct packed {
        logic [XLEN-1:0] data;
        rsp_status_e     status;
    } ls_rsp_t;

endpackage

// ==== verilog/ls_decode.sv ====
`timescale 1ns/1ps

module ls_decode (
    input  logic [lsu_pkg::INSTR_W-1:0] instr_i,
    output lsu_pkg::mem_op_e            op_o
);

    logic [2:0] funct3;
    logic [4:0] opcode;
    logic       full_len;

    assign funct3   = instr_i[14:12];
    assign opcode   = instr_i[6:2];
    // compressed encodings are not memory ops here
    assign full_len = (instr_i[1:0] == 2'b11);

    always_comb begin
        op_o = lsu_pkg::OP_ILLEGAL;
        if (full_len && opcode == lsu_pkg::OPC_LOAD) begin
            case (funct3)
                3'b000:  op_o = lsu_pkg::LB;
                3'b001:  op_o = lsu_pkg::LH;
                3'b010:  op_o = lsu_pkg::LW;
                3'b011:  op_o = lsu_pkg::LD;
                3'b100:  op_o = lsu_pkg::LBU;
                3'b101:  op_o = lsu_pkg::LHU;
                3'b110:  op_o = lsu_pkg::LWU;
                default: op_o = lsu_pkg::OP_ILLEGAL;
            endcase
        end else if (full_len && opcode == lsu_pkg::OPC_STORE) begin
            // stores have no unsigned variants
            case (funct3)
                3'b000:  op_o = lsu_pkg::SB;
                3'b001:  op_o = lsu_pkg::SH;
                3'b010:  op_o = lsu_pkg::SW;
                3'b011:  op_o = lsu_pkg::SD;
                default: op_o = lsu_pkg::OP_ILLEGAL;
            endcase
        end
    end

endmodule

// ==== verilog/ls_req_port.sv ====
`timescale 1ns/1ps

module ls_req_port (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             req_i,
    input  lsu_pkg::ls_req_t req_data_i,
    output logic             ack_o,
    input  logic             busy_i,
    output logic             cmd_valid_o,
    output lsu_pkg::ls_cmd_t cmd_o
);

    typedef enum logic {
        WAIT_REQ,
        WAIT_DROP
    } state_e;

    state_e           state_q;
    lsu_pkg::mem_op_e dec_op;

    ls_decode u_decode (
        .instr_i (req_data_i.instr),
        .op_o    (dec_op)
    );

    // take a request only while idle and the datapath is free
    assign cmd_valid_o = (state_q == WAIT_REQ) && req_i && !busy_i;

    assign cmd_o.op    = dec_op;
    assign cmd_o.addr  = req_data_i.addr;
    assign cmd_o.wdata = req_data_i.wdata;

    // ack is high for the whole drop phase
    assign ack_o = (state_q == WAIT_DROP);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= WAIT_REQ;
        end else begin
            case (state_q)
                WAIT_REQ: begin
                    if (cmd_valid_o) begin
                        state_q <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    // requester releases req after seeing ack
                    if (!req_i) begin
                        state_q <= WAIT_REQ;
                    end
                end
                default: begin
                    state_q <= WAIT_REQ;
                end
            endcase
        end
    end

endmodule

// ==== verilog/ls_datapath.sv ====
`timescale 1ns/1ps

module ls_datapath #(
    parameter int ADDR_W = 8
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     cmd_valid_i,
    input  lsu_pkg::ls_cmd_t         cmd_i,
    output logic                     busy_o,
    input  logic                     rsp_idle_i,
    output logic                     rsp_valid_o,
    output lsu_pkg::ls_rsp_t         rsp_o,
    output logic [ADDR_W-1:0]        ram_addr_o,
    output logic                     ram_we_o,
    output logic [lsu_pkg::XLEN-1:0] ram_wdata_o,
    input  logic [lsu_pkg::XLEN-1:0] ram_rdata_i
);

    typedef enum logic [2:0] {
        IDLE,
        READ,
        MERGE,
        WRITE,
        DONE
    } state_e;

    state_e                   state_q;
    lsu_pkg::ls_cmd_t         cmd_q;
    lsu_pkg::ls_rsp_t         rsp_q;
    logic [lsu_pkg::XLEN-1:0] wdata_q;
    logic [1:0]               in_size;
    logic [1:0]               cur_size;
    logic                     misaligned;
    logic                     refuse;
    logic                     cur_store;
    logic                     load_signed;
    logic [5:0]               lane_shift;
    logic [lsu_pkg::XLEN-1:0] lane_data;
    logic [lsu_pkg::XLEN-1:0] size_mask;
    logic [lsu_pkg::XLEN-1:0] lane_mask;
    logic [lsu_pkg::XLEN-1:0] load_data;
    logic [lsu_pkg::XLEN-1:0] merged;

    // log2 of the access size in bytes
    function automatic logic [1:0] op_size(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: op_size = 2'd1;
            lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: op_size = 2'd2;
            lsu_pkg::LD, lsu_pkg::SD:               op_size = 2'd3;
            default:                                op_size = 2'd0;
        endcase
    endfunction

    assign in_size   = op_size(cmd_i.op);
    assign cur_size  = op_size(cmd_q.op);
    assign cur_store = cmd_q.op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD};
    assign load_signed = !(cmd_q.op inside {lsu_pkg::LBU, lsu_pkg::LHU, lsu_pkg::LWU});

    // natural alignment check on the incoming command
    always_comb begin
        case (in_size)
            2'd1:    misaligned = cmd_i.addr[0];
            2'd2:    misaligned = |cmd_i.addr[1:0];
            2'd3:    misaligned = |cmd_i.addr[2:0];
            default: misaligned = 1'b0;
        endcase
    end

    assign refuse = (cmd_i.op == lsu_pkg::OP_ILLEGAL) || misaligned;

    // byte lane of the access within the dword
    assign lane_shift = {cmd_q.addr[2:0], 3'b000};
    assign lane_data  = ram_rdata_i >> lane_shift;

    always_comb begin
        case (cur_size)
            2'd0: begin
                load_data = {{(lsu_pkg::XLEN-8){load_signed & lane_data[7]}}, lane_data[7:0]};
                size_mask = {{(lsu_pkg::XLEN-8){1'b0}}, 8'hff};
            end
            2'd1: begin
                load_data = {{(lsu_pkg::XLEN-16){load_signed & lane_data[15]}},
                             lane_data[15:0]};
                size_mask = {{(lsu_pkg::XLEN-16){1'b0}}, 16'hffff};
            end
            2'd2: begin
                load_data = {{(lsu_pkg::XLEN-32){load_signed & lane_data[31]}},
                             lane_data[31:0]};
                size_mask = {{(lsu_pkg::XLEN-32){1'b0}}, 32'hffff_ffff};
            end
            default: begin
                load_data = lane_data;
                size_mask = '1;
            end
        endcase
    end

    // new bytes replace only their own lanes
    assign lane_mask = size_mask << lane_shift;
    assign merged    = (ram_rdata_i & ~lane_mask) | ((cmd_q.wdata << lane_shift) & lane_mask);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cmd_valid_i) begin
                        state_q <= refuse ? DONE : READ;
                    end
                end
                READ:    state_q <= MERGE;
                MERGE:   state_q <= cur_store ? WRITE : DONE;
                WRITE:   state_q <= DONE;
                DONE: begin
                    // hold the result until the sender is free
                    if (rsp_idle_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && cmd_valid_i) begin
            cmd_q      <= cmd_i;
            rsp_q.data <= '0;
            if (cmd_i.op == lsu_pkg::OP_ILLEGAL) begin
                rsp_q.status <= lsu_pkg::ST_ILLEGAL;
            end else if (misaligned) begin
                rsp_q.status <= lsu_pkg::ST_MISALIGNED;
            end else begin
                rsp_q.status <= lsu_pkg::ST_OK;
            end
        end
        if (state_q == MERGE) begin
            if (!cur_store) begin
                rsp_q.data <= load_data;
            end
            wdata_q <= merged;
        end
    end

    assign busy_o      = (state_q != IDLE);
    assign rsp_valid_o = (state_q == DONE) && rsp_idle_i;
    assign rsp_o       = rsp_q;

    assign ram_addr_o  = cmd_q.addr[ADDR_W+2:3];
    assign ram_we_o    = (state_q == WRITE);
    assign ram_wdata_o = wdata_q;

endmodule

// ==== verilog/dword_ram.sv ====
`timescale 1ns/1ps

module dword_ram #(
    parameter int ADDR_W = 8
) (
    input  logic                     clk,
    input  logic [ADDR_W-1:0]        addr_i,
    input  logic                     we_i,
    input  logic [lsu_pkg::XLEN-1:0] wdata_i,
    output logic [lsu_pkg::XLEN-1:0] rdata_o
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [lsu_pkg::XLEN-1:0] mem [DEPTH];

    // single port, read data keeps its value during a write
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end else begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

// ==== verilog/ls_rsp_port.sv ====
`timescale 1ns/1ps

module ls_rsp_port (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             rsp_valid_i,
    input  lsu_pkg::ls_rsp_t rsp_i,
    output logic             idle_o,
    output logic             rsp_req_o,
    input  logic             rsp_ack_i,
    output lsu_pkg::ls_rsp_t rsp_data_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DROP
    } state_e;

    state_e           state_q;
    lsu_pkg::ls_rsp_t rsp_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (rsp_valid_i) begin
                        state_q <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (rsp_ack_i) begin
                        state_q <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    // consumer must release ack before the next response
                    if (!rsp_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // response held steady until the next handover
    always_ff @(posedge clk) begin
        if (state_q == IDLE && rsp_valid_i) begin
            rsp_q <= rsp_i;
        end
    end

    assign idle_o     = (state_q == IDLE);
    assign rsp_req_o  = (state_q == WAIT_ACK);
    assign rsp_data_o = rsp_q;

endmodule

// ==== verilog/ls_stage_top.sv ====
`timescale 1ns/1ps

module ls_stage_top #(
    parameter int ADDR_W = 8
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             req_i,
    input  lsu_pkg::ls_req_t req_data_i,
    output logic             ack_o,
    output logic             rsp_req_o,
    input  logic             rsp_ack_i,
    output lsu_pkg::ls_rsp_t rsp_data_o
);

    logic                     busy;
    logic                     cmd_valid;
    lsu_pkg::ls_cmd_t         cmd;
    logic                     rsp_valid;
    lsu_pkg::ls_rsp_t         rsp;
    logic                     rsp_idle;
    logic [ADDR_W-1:0]        ram_addr;
    logic                     ram_we;
    logic [lsu_pkg::XLEN-1:0] ram_wdata;
    logic [lsu_pkg::XLEN-1:0] ram_rdata;

    ls_req_port u_req_port (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .req_data_i  (req_data_i),
        .ack_o       (ack_o),
        .busy_i      (busy),
        .cmd_valid_o (cmd_valid),
        .cmd_o       (cmd)
    );

    ls_datapath #(
        .ADDR_W (ADDR_W)
    ) u_datapath (
        .clk         (clk),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .busy_o      (busy),
        .rsp_idle_i  (rsp_idle),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .ram_addr_o  (ram_addr),
        .ram_we_o    (ram_we),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    dword_ram #(
        .ADDR_W (ADDR_W)
    ) u_ram (
        .clk     (clk),
        .addr_i  (ram_addr),
        .we_i    (ram_we),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    ls_rsp_port u_rsp_port (
        .clk         (clk),
        .rst_i       (rst_i),
        .rsp_valid_i (rsp_valid),
        .rsp_i       (rsp),
        .idle_o      (rsp_idle),
        .rsp_req_o   (rsp_req_o),
        .rsp_ack_i   (rsp_ack_i),
        .rsp_data_o  (rsp_data_o)
    );

endmodule

// ==== sim/ls_stage_asserts.sv ====
`timescale 1ns/1ps

module ls_stage_asserts (
    input logic             clk,
    input logic             rst_i,
    input logic             req_i,
    input logic             ack_i,
    input logic             rsp_req_i,
    input logic             rsp_ack_i,
    input lsu_pkg::ls_rsp_t rsp_data_i
);

    // ack answers a request sampled one cycle earlier
    ack_rise_a : assert property (@(posedge clk) disable iff (rst_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("ack_o rose without req_i high");

    ack_fall_a : assert property (@(posedge clk) disable iff (rst_i)
        $fell(ack_i) |-> !$past(req_i))
        else $error("ack_o fell while req_i was still high");

    // response frozen until the consumer acknowledges
    rsp_hold_a : assert property (@(posedge clk) disable iff (rst_i)
        (rsp_req_i && !rsp_ack_i) |=> $stable(rsp_data_i))
        else $error("rsp_data_o changed before rsp_ack_i");

    rsp_rise_a : assert property (@(posedge clk) disable iff (rst_i)
        $rose(rsp_req_i) |-> !$past(rsp_ack_i))
        else $error("rsp_req_o rose before rsp_ack_i fell");

endmodule

bind ls_stage_top ls_stage_asserts u_asserts (
    .clk        (clk),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .ack_i      (ack_o),
    .rsp_req_i  (rsp_req_o),
    .rsp_ack_i  (rsp_ack_i),
    .rsp_data_i (rsp_data_o)
);

// ==== sim/tb_ls_stage.sv ====
`timescale 1ns/1ps

module tb_ls_stage;

    localparam int          WAIT_LIMIT = 200;
    localparam int          ACK_LINGER = 3;
    localparam logic [63:0] KNOWN      = 64'h80f1_7e02_43a4_5b96;

    typedef struct packed {
        logic [lsu_pkg::INSTR_W-1:0] instr;
        logic [lsu_pkg::XLEN-1:0]    addr;
        logic [lsu_pkg::XLEN-1:0]    wdata;
        logic [lsu_pkg::XLEN-1:0]    exp_data;
        lsu_pkg::rsp_status_e        exp_status;
        int                          hold;
    } row_t;

    logic             clk;
    logic             rst_i;
    logic             req_i;
    lsu_pkg::ls_req_t req_data_i;
    logic             ack_o;
    logic             rsp_req_o;
    logic             rsp_ack_i;
    lsu_pkg::ls_rsp_t rsp_data_o;
    lsu_pkg::ls_rsp_t got;
    logic [31:0]      lfsr_q;
    row_t             rows[$];
    string            row_names[$];

    ls_stage_top #(
        .ADDR_W (8)
    ) u_dut (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .ack_o      (ack_o),
        .rsp_req_o  (rsp_req_o),
        .rsp_ack_i  (rsp_ack_i),
        .rsp_data_o (rsp_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v      = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // rd and rs fields are don't care for this stage
    function automatic logic [31:0] mem_instr(input bit store, input logic [2:0] funct3);
        return {17'h0a5c3, funct3, 5'h09, store ? 7'b0100011 : 7'b0000011};
    endfunction

    // expected load result built byte by byte
    function automatic logic [63:0] lane_value(input logic [63:0] dw, input int off,
                                               input int nbytes, input bit sext);
        logic [63:0] v;
        v = '0;
        for (int b = 0; b < 8; b++) begin
            if (b < nbytes) begin
                v[8*b +: 8] = dw[8*(off+b) +: 8];
            end else if (sext && v[8*nbytes-1]) begin
                v[8*b +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    task automatic add_row(input string name, input logic [31:0] instr, input logic [63:0] addr,
                           input logic [63:0] wdata, input logic [63:0] exp_data,
                           input lsu_pkg::rsp_status_e exp_status, input int hold);
        row_t r;
        r = '{instr, addr, wdata, exp_data, exp_status, hold};
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    task automatic check_data(input string name, input logic [lsu_pkg::XLEN-1:0] exp,
                              input logic [lsu_pkg::XLEN-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s data expected %h actual %h", name, exp, act);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_status(input string name, input lsu_pkg::rsp_status_e exp,
                                input lsu_pkg::rsp_status_e act);
        if (act !== exp) begin
            $display("CHECK FAILED %s status expected %s actual %s", name, exp.name(),
                     act.name());
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // polled on falling edges where DUT outputs are settled
    task automatic wait_level(input bit on_rsp, input logic level, input string what);
        int cnt;
        cnt = 0;
        while ((on_rsp ? rsp_req_o : ack_o) !== level) begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                $display("timeout while waiting for %s", what);
                $display("tests failed");
                $fatal(1, "handshake stalled");
            end
        end
    endtask

    task automatic send_request(input row_t row);
        req_data_i.instr = row.instr;
        req_data_i.addr  = row.addr;
        req_data_i.wdata = row.wdata;
        req_i            = 1'b1;
        wait_level(1'b0, 1'b1, "ack_o to rise");
        req_i = 1'b0;
        wait_level(1'b0, 1'b0, "ack_o to fall");
    endtask

    task automatic receive_response(input int hold, output lsu_pkg::ls_rsp_t rsp);
        wait_level(1'b1, 1'b1, "rsp_req_o to rise");
        // response must stay offered under back-pressure
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            if (rsp_req_o !== 1'b1) begin
                $display("rsp_req_o dropped before rsp_ack_i was raised");
                $display("tests failed");
                $fatal(1, "handshake broken");
            end
        end
        rsp       = rsp_data_o;
        rsp_ack_i = 1'b1;
        wait_level(1'b1, 1'b0, "rsp_req_o to fall");
        // ack stays high a few cycles after the drop
        for (int i = 0; i < ACK_LINGER; i++) begin
            @(negedge clk);
            if (rsp_req_o !== 1'b0) begin
                $display("rsp_req_o rose again while rsp_ack_i was still high");
                $display("tests failed");
                $fatal(1, "handshake broken");
            end
        end
        rsp_ack_i = 1'b0;
    endtask

    task automatic build_table();
        logic [63:0] d;
        logic [63:0] cur;
        logic [63:0] nw;
        int          off;
        int          nb;
        d = take_bits(64);
        add_row("sd_rt", mem_instr(1'b1, 3'b011), 64'h100, d, 64'h0, lsu_pkg::ST_OK, 0);
        add_row("ld_rt", mem_instr(1'b0, 3'b011), 64'h100, 64'h0, d, lsu_pkg::ST_OK, 0);
        // every lane of a known dword in signed and unsigned form
        add_row("sd_known", mem_instr(1'b1, 3'b011), 64'h200, KNOWN, 64'h0, lsu_pkg::ST_OK, 0);
        for (int lg = 0; lg < 3; lg++) begin
            nb = 1 << lg;
            for (off = 0; off < 8; off += nb) begin
                add_row($sformatf("lds%0d_off%0d", nb, off), mem_instr(1'b0, 3'(lg)),
                        64'h200 + 64'(off), 64'h0, lane_value(KNOWN, off, nb, 1'b1),
                        lsu_pkg::ST_OK, 0);
                add_row($sformatf("ldu%0d_off%0d", nb, off), mem_instr(1'b0, 3'(lg + 4)),
                        64'h200 + 64'(off), 64'h0, lane_value(KNOWN, off, nb, 1'b0),
                        lsu_pkg::ST_OK, 0);
            end
        end
        // narrow stores at random aligned offsets
        cur = take_bits(64);
        add_row("sd_base", mem_instr(1'b1, 3'b011), 64'h300, cur, 64'h0, lsu_pkg::ST_OK, 0);
        for (int lg = 0; lg < 3; lg++) begin
            nb  = 1 << lg;
            off = int'(take_bits(3 - lg)) * nb;
            nw  = take_bits(64);
            for (int b = 0; b < nb; b++) begin
                cur[8*(off+b) +: 8] = nw[8*b +: 8];
            end
            add_row($sformatf("st%0d_off%0d", nb, off), mem_instr(1'b1, 3'(lg)),
                    64'h300 + 64'(off), nw, 64'h0, lsu_pkg::ST_OK, 0);
            add_row($sformatf("ld_after_st%0d", nb), mem_instr(1'b0, 3'b011), 64'h300, 64'h0,
                    cur, lsu_pkg::ST_OK, 0);
        end
        // refused accesses leave 0x400 untouched
        d = take_bits(64);
        add_row("sd_ref_base", mem_instr(1'b1, 3'b011), 64'h400, d, 64'h0, lsu_pkg::ST_OK, 0);
        add_row("lh_mis", mem_instr(1'b0, 3'b001), 64'h401, 64'h0, 64'h0,
                lsu_pkg::ST_MISALIGNED, 0);
        add_row("sw_mis", mem_instr(1'b1, 3'b010), 64'h402, ~d, 64'h0, lsu_pkg::ST_MISALIGNED, 0);
        add_row("ld_mis", mem_instr(1'b0, 3'b011), 64'h404, 64'h0, 64'h0,
                lsu_pkg::ST_MISALIGNED, 0);
        add_row("not_mem", 32'h0051_0513, 64'h400, 64'h0, 64'h0, lsu_pkg::ST_ILLEGAL, 0);
        add_row("ld_f3_7", mem_instr(1'b0, 3'b111), 64'h400, 64'h0, 64'h0, lsu_pkg::ST_ILLEGAL, 0);
        add_row("sd_f3_4", mem_instr(1'b1, 3'b100), 64'h400, ~d, 64'h0, lsu_pkg::ST_ILLEGAL, 0);
        add_row("ld_ref_check", mem_instr(1'b0, 3'b011), 64'h400, 64'h0, d, lsu_pkg::ST_OK, 0);
        // consumer stalls while the next request is pending
        for (int i = 0; i < 3; i++) begin
            d = take_bits(64);
            add_row($sformatf("sd_bp%0d", i), mem_instr(1'b1, 3'b011), 64'h500 + 64'(8 * i), d,
                    64'h0, lsu_pkg::ST_OK, int'(take_bits(4)) + 1);
            add_row($sformatf("ld_bp%0d", i), mem_instr(1'b0, 3'b011), 64'h500 + 64'(8 * i),
                    64'h0, d, lsu_pkg::ST_OK, int'(take_bits(4)) + 1);
        end
    endtask

    initial begin
        rst_i      = 1'b1;
        req_i      = 1'b0;
        req_data_i = '0;
        rsp_ack_i  = 1'b0;
        lfsr_q     = 32'h7ce3_e493;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        fork
            begin
                for (int i = 0; i < rows.size(); i++) begin
                    send_request(rows[i]);
                end
            end
            begin
                for (int i = 0; i < rows.size(); i++) begin
                    receive_response(rows[i].hold, got);
                    check_data(row_names[i], rows[i].exp_data, got.data);
                    check_status(row_names[i], rows[i].exp_status, got.status);
                end
            end
        join
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
verilog/lsu_pkg.sv
verilog/ls_decode.sv
verilog/ls_req_port.sv
verilog/ls_datapath.sv
verilog/dword_ram.sv
verilog/ls_rsp_port.sv
verilog/ls_stage_top.sv
sim/ls_stage_asserts.sv
sim/tb_ls_stage.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = tb_ls_stage
FILELIST   = build.f
BUILD      = obj_dir
LOG        = sim.log

.PHONY: all lint clean

all:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "all tests passed" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
